// File: bench/memModel.sv
`timescale 1ns/1ns
`default_nettype none

module memModel import rvIsaPkg::*; (
    input logic clk,
    input logic stallEn,
    input logic [MEM_AW-1:0] iAddr,
    output logic [XLEN-1:0] iRdata,
    output logic iStall,
    input logic dRen,
    input logic dWen,
    input logic [MEM_AW-1:0] dAddr,
    input logic [XLEN-1:0] dWdata,
    output logic [XLEN-1:0] dRdata,
    output logic dStall
);

    logic [XLEN-1:0] prog [256];
    logic [XLEN-1:0] dmem [256];
    logic [MEM_AW-1:0] stAddr [$];     // accepted stores in order
    logic [XLEN-1:0] stData [$];
    integer seed = 32'h6ecc_1a44;

    // nothing valid while a port stalls
    assign iRdata = iStall ? '0 : prog[iAddr[7:0]];
    assign dRdata = (dRen && !dStall) ? dmem[dAddr[7:0]] : '0;

    initial begin
        iStall = 1'b0;
        dStall = 1'b0;
    end

    // roughly one stall in four per port
    always @(negedge clk) begin
        iStall <= stallEn && (($random(seed) & 3) == 0);
        dStall <= stallEn && (($random(seed) & 3) == 0);
    end

    always @(posedge clk) begin
        if (dWen && !dStall) begin
            dmem[dAddr[7:0]] <= dWdata;
            stAddr.push_back(dAddr);
            stData.push_back(dWdata);
        end
    end

endmodule

`default_nettype wire

// File: bench/rvCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module rvCoreTb import rvIsaPkg::*; ();

    localparam int INSTR_TOTAL = 220;      // all programs with loops unrolled
    localparam int STALL_MARGIN = 6;
    localparam int WATCH_NS = (INSTR_TOTAL * STALL_MARGIN + 8 * 40) * 100;

    logic clk;
    logic rst_n;
    logic stallEn;
    logic [MEM_AW-1:0] iAddr;
    logic [XLEN-1:0] iRdata;
    logic iStall;
    logic dRen;
    logic dWen;
    logic [MEM_AW-1:0] dAddr;
    logic [XLEN-1:0] dWdata;
    logic [XLEN-1:0] dRdata;
    logic dStall;

    integer seed = 32'h6ecc_1a44;
    int progLen;
    logic [MEM_AW-1:0] expAddr [$];
    logic [XLEN-1:0] expData [$];

    rvCore UUT (
        .clk(clk), .rst_n(rst_n), .iAddr(iAddr), .iRdata(iRdata), .iStall(iStall),
        .dRen(dRen), .dWen(dWen), .dAddr(dAddr), .dWdata(dWdata),
        .dRdata(dRdata), .dStall(dStall)
    );

    memModel mem (
        .clk(clk), .stallEn(stallEn), .iAddr(iAddr), .iRdata(iRdata), .iStall(iStall),
        .dRen(dRen), .dWen(dWen), .dAddr(dAddr), .dWdata(dWdata),
        .dRdata(dRdata), .dStall(dStall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    initial begin
        #(WATCH_NS);
        reportFailure($sformatf("Timeout: run did not finish by %0t", $time));
    end

    function automatic logic [XLEN-1:0] rInstr(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [XLEN-1:0] immInstr(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [XLEN-1:0] loadInstr(input logic [11:0] imm,
                                                  input logic [4:0] rs1, input logic [4:0] rd);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [XLEN-1:0] storeInstr(input logic [11:0] imm,
                                                   input logic [4:0] rs2, input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [XLEN-1:0] branchInstr(input logic [12:0] off, input logic [4:0] rs2,
                                                    input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // RV32I result by funct3 and funct7 bit 5 (alt)
    function automatic logic [XLEN-1:0] isaResult(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [XLEN-1:0] word);
        mem.prog[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input int byteAddr, input logic [XLEN-1:0] data);
        expAddr.push_back(MEM_AW'(byteAddr >> 2));
        expData.push_back(data);
    endtask

    // holds reset and clears memories, stores and expectations
    task automatic beginTest(input logic stalls);
        @(negedge clk);
        rst_n = 1'b0;
        stallEn = stalls;
        for (int i = 0; i < 256; i++) begin
            mem.prog[i] = '0;      // zero word decodes as a bubble
            mem.dmem[i] = i * 32'h0001_0003 + 32'h1000_0000;
        end
        mem.stAddr.delete();
        mem.stData.delete();
        expAddr.delete();
        expData.delete();
        progLen = 0;
    endtask

    task automatic runAndCheck(input string name);
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        while (mem.stAddr.size() < expAddr.size()) begin
            @(posedge clk);
        end
        repeat (20) @(negedge clk);     // drain so stray stores show up
        assert (mem.stAddr.size() == expAddr.size()) else
            reportFailure($sformatf("Mismatch at %0t: %s made %0d stores, expected %0d",
                                    $time, name, mem.stAddr.size(), expAddr.size()));
        for (int i = 0; i < expAddr.size(); i++) begin
            assert (mem.stAddr[i] == expAddr[i] && mem.stData[i] == expData[i]) else
                reportFailure($sformatf("Mismatch at %0t: %s store %0d got %h:%h expected %h:%h",
                                        $time, name, i, mem.stAddr[i], mem.stData[i],
                                        expAddr[i], expData[i]));
        end
    endtask

    task automatic aluTest(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                           input logic [11:0] imm);
        logic [2:0] rF3 [9] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5, 3'd5};
        logic rAlt [9] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        logic [2:0] iF3 [8] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5, 3'd5};
        logic iAlt [8] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
        logic [11:0] immField;
        int off;
        beginTest(1'b0);
        mem.dmem[0] = a;
        mem.dmem[1] = b;
        emit(loadInstr(12'd0, 5'd0, 5'd1));
        emit(loadInstr(12'd4, 5'd0, 5'd2));
        off = 512;
        for (int k = 0; k < 9; k++) begin
            emit(rInstr(rAlt[k] ? 7'b0100000 : 7'b0, 5'd2, 5'd1, rF3[k], 5'd3));
            emit(storeInstr(12'(off), 5'd3, 5'd0));
            expectStore(off, isaResult(rF3[k], rAlt[k], a, b));
            off += 4;
        end
        for (int k = 0; k < 8; k++) begin
            if (iF3[k] == 3'd1 || iF3[k] == 3'd5) begin
                immField = {iAlt[k] ? 7'b0100000 : 7'b0, imm[4:0]};
            end else begin
                immField = imm;
            end
            emit(immInstr(immField, 5'd1, iF3[k], 5'd3));
            emit(storeInstr(12'(off), 5'd3, 5'd0));
            expectStore(off, isaResult(iF3[k], iAlt[k], a, {{20{immField[11]}}, immField}));
            off += 4;
        end
        runAndCheck("alu");
    endtask

    task automatic forwardTest();
        logic [XLEN-1:0] v1;
        logic [XLEN-1:0] v2;
        logic [XLEN-1:0] v3;
        logic [XLEN-1:0] v4;
        beginTest(1'b0);
        v1 = 32'd5;
        v2 = v1 + 32'd7;
        v3 = v1 + v2;
        v4 = v3 - v1;
        emit(immInstr(12'd5, 5'd0, 3'd0, 5'd1));
        emit(immInstr(12'd7, 5'd1, 3'd0, 5'd2));       // x1 from mem stage
        emit(rInstr(7'b0, 5'd2, 5'd1, 3'd0, 5'd3));    // x1 from wb, x2 from mem
        emit(rInstr(7'b0100000, 5'd1, 5'd3, 3'd0, 5'd4));
        emit(storeInstr(12'h200, 5'd4, 5'd0));
        emit(rInstr(7'b0, 5'd2, 5'd4, 3'd4, 5'd5));
        emit(storeInstr(12'h204, 5'd5, 5'd0));
        emit(storeInstr(12'h208, 5'd3, 5'd0));
        expectStore(12'h200, v4);
        expectStore(12'h204, v4 ^ v2);
        expectStore(12'h208, v3);
        runAndCheck("forward");
    endtask

    task automatic loadUseTest();
        logic [XLEN-1:0] val;
        logic [10:0] addend;
        beginTest(1'b0);
        val = $random(seed);
        addend = 11'($random(seed));
        mem.dmem[40] = val;
        emit(immInstr({1'b0, addend}, 5'd0, 3'd0, 5'd7));
        emit(loadInstr(12'd160, 5'd0, 5'd5));
        emit(rInstr(7'b0, 5'd7, 5'd5, 3'd0, 5'd6));    // stalls one cycle
        emit(storeInstr(12'h200, 5'd6, 5'd0));
        emit(storeInstr(12'h204, 5'd5, 5'd0));
        expectStore(12'h200, val + {21'b0, addend});
        expectStore(12'h204, val);
        runAndCheck("load-use");
    endtask

    task automatic loopTest(input logic stalls);
        int count;
        int sum;
        beginTest(stalls);
        count = 5;
        sum = 0;
        emit(immInstr(12'(count), 5'd0, 3'd0, 5'd1));
        emit(immInstr(12'd0, 5'd0, 3'd0, 5'd2));
        emit(immInstr(12'd3, 5'd2, 3'd0, 5'd2));       // loop top at 8
        emit(immInstr(12'hFFF, 5'd1, 3'd0, 5'd1));
        emit(branchInstr(13'd12, 5'd0, 5'd1, 3'd0));   // beq to exit at 28
        emit(branchInstr(-13'sd12, 5'd0, 5'd1, 3'd1)); // bne back to 8
        emit(storeInstr(12'h300, 5'd1, 5'd0));         // marker store that must never appear
        emit(storeInstr(12'h200, 5'd2, 5'd0));
        emit(storeInstr(12'h204, 5'd1, 5'd0));
        while (count != 0) begin
            sum += 3;
            count--;
        end
        expectStore(12'h200, 32'(sum));
        expectStore(12'h204, 32'(count));
        runAndCheck(stalls ? "loop with stalls" : "loop");
    endtask

    task automatic resetPortTest();
        beginTest(1'b0);
        emit(immInstr(12'd1, 5'd0, 3'd0, 5'd1));
        emit(immInstr(12'd2, 5'd0, 3'd0, 5'd2));
        emit(immInstr(12'd3, 5'd0, 3'd0, 5'd3));
        emit(storeInstr(12'h200, 5'd3, 5'd0));         // fetched in cycle 3
        repeat (10) begin
            @(negedge clk);
            assert (!dRen && !dWen && iAddr == '0) else
                reportFailure($sformatf("Mismatch at %0t: ports not idle during reset",
                                        $time));
        end
        rst_n = 1'b1;
        for (int p = 1; p <= 6; p++) begin
            @(negedge clk);
            assert (iAddr == MEM_AW'(p)) else
                reportFailure($sformatf("Mismatch at %0t: iAddr %0d in cycle %0d, expected %0d",
                                        $time, iAddr, p, p));
            if (p < 6) begin
                assert (!dRen && !dWen) else
                    reportFailure($sformatf("Mismatch at %0t: data port active in cycle %0d",
                                            $time, p));
            end else begin
                assert (dWen && !dRen && dAddr == MEM_AW'(12'h200 >> 2) && dWdata == 32'd3)
                else
                    reportFailure($sformatf("Mismatch at %0t: store not on port in cycle 6",
                                            $time));
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        stallEn = 1'b0;
        progLen = 0;
        resetPortTest();
        aluTest(32'h8000_00F0, 32'h0000_0013, 12'hF85);
        aluTest($random(seed), $random(seed), 12'($random(seed)));
        forwardTest();
        loadUseTest();
        loopTest(1'b0);
        loopTest(1'b1);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/rvIsaPkg.sv
src/rvPipePkg.sv
src/bypassIf.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memWbStage.sv
src/rvCore.sv
bench/memModel.sv
bench/rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rvCore testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f files.f --top-module rvCoreTb -o rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

if [ ! -x obj_dir/rvCoreSim ]; then
    echo "simulation binary not found"
    exit 1
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: src/bypassIf.sv
`timescale 1ns/1ns
`default_nettype none

interface bypassIf import rvIsaPkg::*; ();

    // mem stage, straight from EX/MEM
    logic memRegWrite;
    logic [REG_AW-1:0] memRd;
    logic [XLEN-1:0] memData;
    logic memIsLoad;        // memData is only the address then

    // wb stage, value already selected
    logic wbRegWrite;
    logic [REG_AW-1:0] wbRd;
    logic [XLEN-1:0] wbData;

    modport memSrc (output memRegWrite, memRd, memData, memIsLoad);

    modport wbSrc (output wbRegWrite, wbRd, wbData);

    modport sink (
        input memRegWrite, memRd, memData, memIsLoad,
        input wbRegWrite, wbRd, wbData
    );

endinterface

`default_nettype wire

// File: src/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage import rvIsaPkg::*, rvPipePkg::*; (
    input logic clk,
    input logic rst_n,
    input logic dStall,
    input ifIdT ifId,
    bypassIf.sink fwd,
    input logic [REG_AW-1:0] exRd,
    input logic exMemRead,
    input logic exRegWrite,
    input logic rfWen,
    input logic [REG_AW-1:0] rfRd,
    input logic [XLEN-1:0] rfData,
    output logic hazardStall,
    output logic branchTaken,
    output logic [XLEN-1:0] branchTarget,
    output idExT idEx
);

    logic [XLEN-1:0] instr;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [F3_W-1:0] funct3;
    opcodeE opc;
    logic legal;
    logic isBranch;
    ctrlT ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rData1;
    logic [XLEN-1:0] rData2;
    logic [XLEN-1:0] cmpA;
    logic [XLEN-1:0] cmpB;
    logic exHit;
    logic memHit;
    logic loadUse;
    logic brExDep;
    logic brMemLoad;

    assign instr = ifId.instr;
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd = instr[11:7];
    assign funct3 = instr[14:12];
    assign opc = opcodeE'(instr[6:2]);
    assign legal = ifId.valid && (instr[1:0] == 2'b11);
    assign isBranch = legal && (opc == OP_BRANCH);

    always_comb begin
        ctrl = '0;
        if (legal) begin
            case (opc)
                OP_REG: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp = funct3;
                end
                OP_IMM: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc = 1'b1;
                    ctrl.aluOp = funct3;
                end
                OP_LOAD: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.aluSrc = 1'b1;
                end
                OP_STORE: begin
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrc = 1'b1;
                end
                default: ctrl = '0;     // branch or unknown
            endcase
        end
    end

    always_comb begin
        case (opc)
            OP_STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            // also R type so funct7 bit 5 lands at imm[10] for execute
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    regFile rf (
        .clk(clk),
        .rst_n(rst_n),
        .rs1(rs1),
        .rs2(rs2),
        .rfRd(rfRd),
        .rfWen(rfWen),
        .rfData(rfData),
        .rData1(rData1),
        .rData2(rData2)
    );

    assign cmpA = fwdSelect(rs1, rData1, fwd.memRegWrite, fwd.memRd, fwd.memData,
                            fwd.wbRegWrite, fwd.wbRd, fwd.wbData);
    assign cmpB = fwdSelect(rs2, rData2, fwd.memRegWrite, fwd.memRd, fwd.memData,
                            fwd.wbRegWrite, fwd.wbRd, fwd.wbData);

    assign exHit = exRd != '0 && (exRd == rs1 || exRd == rs2);
    assign memHit = fwd.memRd != '0 && (fwd.memRd == rs1 || fwd.memRd == rs2);
    assign loadUse = exMemRead && exHit;
    assign brExDep = isBranch && exRegWrite && exHit;     // alu or load still in EX
    assign brMemLoad = isBranch && fwd.memIsLoad && fwd.memRegWrite && memHit;
    assign hazardStall = legal && (loadUse || brExDep || brMemLoad);

    assign branchTarget = ifId.pc + imm;
    assign branchTaken = isBranch && !brExDep && !brMemLoad &&
                         ((funct3 == F3_BEQ && cmpA == cmpB) ||
                          (funct3 == F3_BNE && cmpA != cmpB));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idEx.ctrl <= '0;
        end else if (!dStall) begin
            idEx.ctrl <= (hazardStall || branchTaken) ? '0 : ctrl;
            idEx.rs1 <= rs1;
            idEx.rs2 <= rs2;
            idEx.rd <= rd;
            idEx.rData1 <= rData1;
            idEx.rData2 <= rData2;
            idEx.imm <= imm;
        end
    end

    // branch stall terms must cover every hazard a branch can see
    noStallRedirect: assert property (@(posedge clk) disable iff (!rst_n)
        !(hazardStall && branchTaken));

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage import rvIsaPkg::*, rvPipePkg::*; (
    input logic clk,
    input logic rst_n,
    input logic dStall,
    input idExT idEx,
    bypassIf.sink fwd,
    bypassIf.memSrc byp,
    output logic [REG_AW-1:0] exRd,
    output logic exMemRead,
    output logic exRegWrite,
    output exMemT exMem,
    output logic dRen,
    output logic dWen,
    output logic [MEM_AW-1:0] dAddr,
    output logic [XLEN-1:0] dWdata
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] rs2Val;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;
    aluOpE op;

    assign opA = fwdSelect(idEx.rs1, idEx.rData1, fwd.memRegWrite, fwd.memRd, fwd.memData,
                           fwd.wbRegWrite, fwd.wbRd, fwd.wbData);
    assign rs2Val = fwdSelect(idEx.rs2, idEx.rData2, fwd.memRegWrite, fwd.memRd, fwd.memData,
                              fwd.wbRegWrite, fwd.wbRd, fwd.wbData);
    assign opB = idEx.ctrl.aluSrc ? idEx.imm : rs2Val;

    // imm[10] is funct7 bit 5 for R type and shift immediates
    always_comb begin
        case (idEx.ctrl.aluOp)
            F3_ADDSUB: op = (!idEx.ctrl.aluSrc && idEx.imm[10]) ? ALU_SUB : ALU_ADD;
            F3_SLL: op = ALU_SLL;
            F3_SLT: op = ALU_SLT;
            F3_XOR: op = ALU_XOR;
            F3_SR: op = idEx.imm[10] ? ALU_SRA : ALU_SRL;
            F3_OR: op = ALU_OR;
            F3_AND: op = ALU_AND;
            default: op = ALU_ADD;      // sltu not supported
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;
            ALU_AND: aluOut = opA & opB;
            ALU_OR: aluOut = opA | opB;
            ALU_XOR: aluOut = opA ^ opB;
            ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
            ALU_SLL: aluOut = opA << opB[4:0];
            ALU_SRL: aluOut = opA >> opB[4:0];
            ALU_SRA: aluOut = $signed(opA) >>> opB[4:0];
            default: aluOut = '0;
        endcase
    end

    assign exRd = idEx.rd;
    assign exMemRead = idEx.ctrl.memRead;
    assign exRegWrite = idEx.ctrl.regWrite;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.memToReg <= 1'b0;
        end else if (!dStall) begin
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.memRead <= idEx.ctrl.memRead;
            exMem.memWrite <= idEx.ctrl.memWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
            exMem.rd <= idEx.rd;
            exMem.aluOut <= aluOut;
            exMem.storeData <= rs2Val;
        end
    end

    assign dRen = exMem.memRead;
    assign dWen = exMem.memWrite;
    assign dAddr = exMem.aluOut[XLEN-1:XLEN-MEM_AW];
    assign dWdata = exMem.storeData;

    assign byp.memRegWrite = exMem.regWrite;
    assign byp.memRd = exMem.rd;
    assign byp.memData = exMem.aluOut;
    assign byp.memIsLoad = exMem.memRead;

    dPortExclusive: assert property (@(posedge clk) disable iff (!rst_n) !(dRen && dWen));

endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage import rvIsaPkg::*, rvPipePkg::*; (
    input logic clk,
    input logic rst_n,
    input logic iStall,
    input logic dStall,
    input logic hazardStall,
    input logic branchTaken,
    input logic [XLEN-1:0] branchTarget,
    input logic [XLEN-1:0] iRdata,
    output logic [MEM_AW-1:0] iAddr,
    output ifIdT ifId
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;

    assign pcPlus4 = pc + 32'd4;
    assign iAddr = pc[XLEN-1:XLEN-MEM_AW];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
            ifId.valid <= 1'b0;
            ifId.instr <= NOP_WORD;
        end else if (!dStall && !hazardStall) begin
            if (branchTaken || iStall) begin
                // younger slot dropped, or nothing fetched yet
                pc <= branchTaken ? branchTarget : pc;
                ifId.valid <= 1'b0;
                ifId.pc <= pc;
                ifId.instr <= NOP_WORD;
            end else begin
                pc <= pcPlus4;
                ifId.valid <= 1'b1;
                ifId.pc <= pc;
                ifId.instr <= iRdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/memWbStage.sv
`timescale 1ns/1ns
`default_nettype none

module memWbStage import rvIsaPkg::*, rvPipePkg::*; (
    input logic clk,
    input logic rst_n,
    input logic dStall,
    input exMemT exMem,
    input logic [XLEN-1:0] dRdata,
    bypassIf.wbSrc byp,
    output logic rfWen,
    output logic [REG_AW-1:0] rfRd,
    output logic [XLEN-1:0] rfData
);

    memWbT memWb;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            memWb.regWrite <= 1'b0;
            memWb.memToReg <= 1'b0;
        end else if (!dStall) begin     // dRdata only good without stall
            memWb.regWrite <= exMem.regWrite;
            memWb.memToReg <= exMem.memToReg;
            memWb.rd <= exMem.rd;
            memWb.aluOut <= exMem.aluOut;
            memWb.loadData <= dRdata;
        end
    end

    assign rfWen = memWb.regWrite;
    assign rfRd = memWb.rd;
    assign rfData = memWb.memToReg ? memWb.loadData : memWb.aluOut;

    assign byp.wbRegWrite = rfWen;
    assign byp.wbRd = rfRd;
    assign byp.wbData = rfData;

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile import rvIsaPkg::*; (
    input logic clk,
    input logic rst_n,
    input logic [REG_AW-1:0] rs1,
    input logic [REG_AW-1:0] rs2,
    input logic [REG_AW-1:0] rfRd,
    input logic rfWen,
    input logic [XLEN-1:0] rfData,
    output logic [XLEN-1:0] rData1,
    output logic [XLEN-1:0] rData2
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rfWen && rfRd != '0) begin
            regs[rfRd] <= rfData;
        end
    end

    // same-cycle write shows through
    assign rData1 = (rfWen && rfRd != '0 && rfRd == rs1) ? rfData : regs[rs1];
    assign rData2 = (rfWen && rfRd != '0 && rfRd == rs2) ? rfData : regs[rs2];

    // x0 reads zero even while being written
    x0Zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 != '0 || rData1 == '0) && (rs2 != '0 || rData2 == '0));

endmodule

`default_nettype wire

// File: src/rvCore.sv
`timescale 1ns/1ns
`default_nettype none

module rvCore import rvIsaPkg::*, rvPipePkg::*; (
    input logic clk,
    input logic rst_n,
    output logic [MEM_AW-1:0] iAddr,
    input logic [XLEN-1:0] iRdata,
    input logic iStall,
    output logic dRen,
    output logic dWen,
    output logic [MEM_AW-1:0] dAddr,
    output logic [XLEN-1:0] dWdata,
    input logic [XLEN-1:0] dRdata,
    input logic dStall
);

    ifIdT ifId;
    idExT idEx;
    exMemT exMem;
    logic hazardStall;
    logic branchTaken;
    logic [XLEN-1:0] branchTarget;
    logic [REG_AW-1:0] exRd;
    logic exMemRead;
    logic exRegWrite;
    logic rfWen;
    logic [REG_AW-1:0] rfRd;
    logic [XLEN-1:0] rfData;

    bypassIf byp ();

    fetchStage fetch (
        .clk(clk), .rst_n(rst_n), .iStall(iStall), .dStall(dStall),
        .hazardStall(hazardStall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .iRdata(iRdata), .iAddr(iAddr), .ifId(ifId)
    );

    decodeStage decode (
        .clk(clk), .rst_n(rst_n), .dStall(dStall), .ifId(ifId), .fwd(byp),
        .exRd(exRd), .exMemRead(exMemRead), .exRegWrite(exRegWrite),
        .rfWen(rfWen), .rfRd(rfRd), .rfData(rfData),
        .hazardStall(hazardStall), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .idEx(idEx)
    );

    executeStage execute (
        .clk(clk), .rst_n(rst_n), .dStall(dStall), .idEx(idEx), .fwd(byp), .byp(byp),
        .exRd(exRd), .exMemRead(exMemRead), .exRegWrite(exRegWrite), .exMem(exMem),
        .dRen(dRen), .dWen(dWen), .dAddr(dAddr), .dWdata(dWdata)
    );

    memWbStage memWb (
        .clk(clk), .rst_n(rst_n), .dStall(dStall), .exMem(exMem), .dRdata(dRdata),
        .byp(byp), .rfWen(rfWen), .rfRd(rfRd), .rfData(rfData)
    );

endmodule

`default_nettype wire

// File: src/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam int NUM_REGS = 32;
    localparam int MEM_AW = 30;     // word address, byte offset dropped

    localparam int OPC_W = 5;       // instr[6:2]
    localparam int ALUOP_W = 4;
    localparam int F3_W = 3;

    // major opcodes, instr[6:2]
    typedef enum logic [OPC_W-1:0] {
        OP_LOAD   = 5'b00000,
        OP_IMM    = 5'b00100,
        OP_STORE  = 5'b01000,
        OP_REG    = 5'b01100,
        OP_BRANCH = 5'b11000
    } opcodeE;

    typedef enum logic [ALUOP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA
    } aluOpE;

    localparam logic [F3_W-1:0] F3_ADDSUB = 3'b000;
    localparam logic [F3_W-1:0] F3_SLL    = 3'b001;
    localparam logic [F3_W-1:0] F3_SLT    = 3'b010;
    localparam logic [F3_W-1:0] F3_XOR    = 3'b100;
    localparam logic [F3_W-1:0] F3_SR     = 3'b101;   // srl / sra by funct7 bit 5
    localparam logic [F3_W-1:0] F3_OR     = 3'b110;
    localparam logic [F3_W-1:0] F3_AND    = 3'b111;
    localparam logic [F3_W-1:0] F3_BEQ    = 3'b000;
    localparam logic [F3_W-1:0] F3_BNE    = 3'b001;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_WORD = 32'h0000_0013;

endpackage

`default_nettype wire

// File: src/rvPipePkg.sv
`default_nettype none

package rvPipePkg;
    import rvIsaPkg::*;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic aluSrc;
        logic [F3_W-1:0] aluOp;     // funct3, zero for memory ops
    } ctrlT;

    typedef struct packed {
        logic valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT ctrl;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0] rData1;
        logic [XLEN-1:0] rData2;
        logic [XLEN-1:0] imm;
    } idExT;

    typedef struct packed {
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0] aluOut;
        logic [XLEN-1:0] storeData;
    } exMemT;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0] aluOut;
        logic [XLEN-1:0] loadData;
    } memWbT;

    // operand bypass, mem stage wins over wb stage
    function automatic logic [XLEN-1:0] fwdSelect(
        input logic [REG_AW-1:0] rs,
        input logic [XLEN-1:0] regVal,
        input logic memRegWrite,
        input logic [REG_AW-1:0] memRd,
        input logic [XLEN-1:0] memData,
        input logic wbRegWrite,
        input logic [REG_AW-1:0] wbRd,
        input logic [XLEN-1:0] wbData
    );
        if (memRegWrite && memRd != '0 && memRd == rs) begin
            return memData;
        end else if (wbRegWrite && wbRd != '0 && wbRd == rs) begin
            return wbData;
        end
        return regVal;
    endfunction

endpackage

`default_nettype wire
